/* Makefile */
VERILATOR ?= verilator
TOP       ?= tbCpu
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* cpuPkg.sv */
/*
  Shared types for the pipelined core.
  Only the kept opcode subset is enumerated; other encodings decode as no-ops.
  Payload structs are packed, so an all-zero value is a bubble (add r0).
*/
`default_nettype none
`include "cpu_defines.svh"

package cpuPkg;

    typedef logic [`WORD_BITS-1:0] wordT;
    typedef logic [`REG_IDX_BITS-1:0] regIdxT;
    typedef logic [`MEM_ADDR_BITS-1:0] memAddrT;

    // Opcode field, instruction bits 31:27
    typedef enum logic [4:0] {
        opRType = 5'b00000,
        opJ     = 5'b00001,
        opBne   = 5'b00010,
        opAddi  = 5'b00101,
        opBlt   = 5'b00110,
        opSw    = 5'b00111,
        opLw    = 5'b01000
    } opcodeT;

    // ALU op field of R-type, bits 6:2
    typedef enum logic [4:0] {
        aluAdd = 5'b00000,
        aluSub = 5'b00001,
        aluAnd = 5'b00010,
        aluOr  = 5'b00011,
        aluSll = 5'b00100,
        aluSra = 5'b00101
    } aluOpT;

    ////////////////////////////////////////
    // Pipeline register payloads
    ////////////////////////////////////////

    typedef struct packed {
        wordT instr;
        wordT pcPlus1;
    } fdPayloadT;

    typedef struct packed {
        wordT   instr;
        wordT   pcPlus1;
        wordT   aVal;
        wordT   bVal;
        regIdxT bIdx;
    } dxPayloadT;

    typedef struct packed {
        wordT instr;
        wordT result;     // ALU value, also the memory address for lw/sw
        wordT storeData;
    } xmPayloadT;

    // Instructions that write rd at writeback
    function automatic logic writesRd(opcodeT op);
        return op inside {opRType, opAddi, opLw};
    endfunction

    // Branches and sw read rd on register port B instead of rt
    function automatic logic readsRdAsB(opcodeT op);
        return op inside {opBne, opBlt, opSw};
    endfunction

endpackage

`default_nettype wire

/* cpuTop.sv */
/*
  Top level of the five-stage core.
  Register file and both memories live outside and are reached by plain ports.
  The register file must be write-through for same-cycle read of a write.
  Memories must return read data combinationally.
*/
`default_nettype none

module cpuTop (
    input  logic            clock,
    input  logic            rst,
    // Instruction memory
    output cpuPkg::memAddrT imemAddr,
    input  cpuPkg::wordT    imemData,
    // Data memory
    output cpuPkg::memAddrT dmemAddr,
    output cpuPkg::wordT    dmemWriteData,
    output logic            dmemWrite,
    input  cpuPkg::wordT    dmemReadData,
    // Register file
    output cpuPkg::regIdxT  regReadIdxA,
    output cpuPkg::regIdxT  regReadIdxB,
    input  cpuPkg::wordT    regReadDataA,
    input  cpuPkg::wordT    regReadDataB,
    output logic            regWrite,
    output cpuPkg::regIdxT  regWriteIdx,
    output cpuPkg::wordT    regWriteData
);
    import cpuPkg::*;

    // Stage payloads
    fdPayloadT fd;
    dxPayloadT dx;
    xmPayloadT xm;

    // Hazard and control transfer
    logic loadStall;
    logic redirect;
    wordT redirectPc;
    wordT pcPlus1;

    forwardIf fwdBus ();

    fetchStage fetch (
        .clock      (clock),
        .rst        (rst),
        .loadStall  (loadStall),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .imemAddr   (imemAddr),
        .imemData   (imemData),
        .pcPlus1    (pcPlus1),
        .fd         (fd)
    );

    decodeStage decode (
        .clock        (clock),
        .rst          (rst),
        .fd           (fd),
        .redirect     (redirect),
        .regReadIdxA  (regReadIdxA),
        .regReadIdxB  (regReadIdxB),
        .regReadDataA (regReadDataA),
        .regReadDataB (regReadDataB),
        .loadStall    (loadStall),
        .dx           (dx)
    );

    executeStage execute (
        .clock      (clock),
        .rst        (rst),
        .dx         (dx),
        .pcPlus1    (pcPlus1),
        .fwd        (fwdBus.sink),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .xm         (xm)
    );

    memoryStage memory (
        .clock         (clock),
        .rst           (rst),
        .xm            (xm),
        .fwd           (fwdBus.source),
        .dmemAddr      (dmemAddr),
        .dmemWriteData (dmemWriteData),
        .dmemWrite     (dmemWrite),
        .dmemReadData  (dmemReadData),
        .regWrite      (regWrite),
        .regWriteIdx   (regWriteIdx),
        .regWriteData  (regWriteData)
    );

endmodule

`default_nettype wire

/* cpu_defines.svh */
/*
  Global sizing for the five-stage integer core.
  Word and register widths follow the instruction encoding and must not change.
  MEM_ADDR_BITS sets the address width driven to both memories.
  Register 0 reads as zero and is never a bypass or writeback target.
*/
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Data and instruction width
`define WORD_BITS 32

// Register file shape
`define REG_COUNT 32
`define REG_IDX_BITS 5

// Address width toward instruction and data memory
`define MEM_ADDR_BITS 12

// Hardwired zero register, excluded from bypass and writeback
`define ZERO_REG 5'd0

`endif

/* cpu_trace.txt */
# I <instruction hex> | R <test> <reg dec> <value hex> | S <test> <addr hex> <data hex>
# Program words load from address 0; R and S lines are expected in program order
I 28400005
I 28800003
I 00C22000
I 01061004
I 01483008
I 018A300C
I 29C1FFEC
I 020E0110
I 02500194
I 39820004
I 42820004
I 02D42000
I 10440002
I 2B000001
I 2B400001
I 10880001
I 2B800007
I 31C20001
I 2BC00009
I 304E0005
I 2C00000C
I 08000018
I 2C400001
I 2C800001
I 2CC00021
I 00022000
I 3CC00000
I 0800001B
R 1 1 00000005
R 1 2 00000003
R 1 3 00000008
R 1 4 00000003
R 1 5 00000000
R 1 6 00000008
R 2 7 FFFFFFEC
R 2 8 FFFFFFB0
R 2 9 FFFFFFF6
S 3 009 00000008
R 3 10 00000008
R 3 11 0000000B
R 4 14 00000007
R 4 16 0000000C
R 5 19 00000021
S 6 000 00000021

/* decodeStage.sv */
/*
  Register read and DX register.
  Port A always reads rs; port B reads rd for branches and sw, rt otherwise.
  The register file is write-through, so no writeback-to-decode bypass is needed.
  A load-use hazard stalls one cycle and injects a bubble into DX.
*/
`default_nettype none
`include "cpu_defines.svh"

module decodeStage (
    input  logic              clock,
    input  logic              rst,
    input  cpuPkg::fdPayloadT fd,
    input  logic              redirect,
    output cpuPkg::regIdxT    regReadIdxA,
    output cpuPkg::regIdxT    regReadIdxB,
    input  cpuPkg::wordT      regReadDataA,
    input  cpuPkg::wordT      regReadDataB,
    output logic              loadStall,
    output cpuPkg::dxPayloadT dx
);
    import cpuPkg::*;

    opcodeT fdOp;
    regIdxT fdRd;
    regIdxT fdRs;
    regIdxT fdRt;
    opcodeT dxOp;
    regIdxT dxRd;
    logic   dxIsLoad;

    ////////////////////////////////////////
    // Field split of the FD instruction
    ////////////////////////////////////////
    assign fdOp = opcodeT'(fd.instr[31:27]);
    assign fdRd = fd.instr[26:22];
    assign fdRs = fd.instr[21:17];
    assign fdRt = fd.instr[16:12];

    // Read ports
    assign regReadIdxA = fdRs;
    assign regReadIdxB = readsRdAsB(fdOp) ? fdRd : fdRt;

    // Load in DX with a live destination
    assign dxOp     = opcodeT'(dx.instr[31:27]);
    assign dxRd     = dx.instr[26:22];
    assign dxIsLoad = (dxOp == opLw) && (dxRd != `ZERO_REG);

    // sw takes its store data through the memory-stage bypass
    // so only its base register can cause a stall
    assign loadStall = dxIsLoad &&
                       ((fdRs == dxRd) || ((regReadIdxB == dxRd) && (fdOp != opSw)));

    ////////////////////////////////////////
    // DX register
    ////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (rst || loadStall || redirect) begin
            dx <= '0;
        end else begin
            dx.instr   <= fd.instr;
            dx.pcPlus1 <= fd.pcPlus1;
            dx.aVal    <= regReadDataA;
            dx.bVal    <= regReadDataB;
            dx.bIdx    <= regReadIdxB;
        end
    end

    // A load and a control transfer can never sit in execute together
    noStallOnRedirect: assert property (@(posedge clock) disable iff (rst)
        !(loadStall && redirect));

endmodule

`default_nettype wire

/* executeStage.sv */
/*
  Operand bypass, ALU, branch resolution and XM register.
  XM has priority over MW when both match an operand index.
  addi, lw and sw add the sign-extended 17-bit immediate.
  bne/blt compare rd (port B) against rs (port A); blt is signed.
  Branch target is PC+1+imm, j target is the zero-extended 27-bit field.
*/
`default_nettype none

module executeStage (
    input  logic              clock,
    input  logic              rst,
    input  cpuPkg::dxPayloadT dx,
    input  cpuPkg::wordT      pcPlus1,
    forwardIf.sink            fwd,
    output logic              redirect,
    output cpuPkg::wordT      redirectPc,
    output cpuPkg::xmPayloadT xm
);
    import cpuPkg::*;

    opcodeT op;
    aluOpT  aluOp;
    regIdxT aIdx;
    logic   [4:0] shamt;
    wordT   imm;
    wordT   target;
    wordT   aFwd;
    wordT   bFwd;
    wordT   aluB;
    wordT   aluResult;
    logic   useImm;
    logic   branchTaken;

    assign op     = opcodeT'(dx.instr[31:27]);
    assign aIdx   = dx.instr[21:17];
    assign shamt  = dx.instr[11:7];
    assign imm    = {{($bits(wordT)-17){dx.instr[16]}}, dx.instr[16:0]};
    assign target = {{($bits(wordT)-27){1'b0}}, dx.instr[26:0]};

    ////////////////////////////////////////
    // Operand bypass
    ////////////////////////////////////////
    always_comb begin
        if (fwd.xmWrites && (fwd.xmRd == aIdx)) begin
            aFwd = fwd.xmValue;
        end else if (fwd.mwWrites && (fwd.mwRd == aIdx)) begin
            aFwd = fwd.mwValue;
        end else begin
            aFwd = dx.aVal;
        end

        if (fwd.xmWrites && (fwd.xmRd == dx.bIdx)) begin
            bFwd = fwd.xmValue;
        end else if (fwd.mwWrites && (fwd.mwRd == dx.bIdx)) begin
            bFwd = fwd.mwValue;
        end else begin
            bFwd = dx.bVal;
        end
    end

    ////////////////////////////////////////
    // ALU
    ////////////////////////////////////////
    assign useImm = op inside {opAddi, opLw, opSw};
    assign aluB   = useImm ? imm : bFwd;

    // Branches subtract, immediates and j add, R-type uses its own field
    always_comb begin
        if (op inside {opBne, opBlt}) begin
            aluOp = aluSub;
        end else if (op == opRType) begin
            aluOp = aluOpT'(dx.instr[6:2]);
        end else begin
            aluOp = aluAdd;
        end
    end

    always_comb begin
        case (aluOp)
            aluAdd:  aluResult = aFwd + aluB;
            aluSub:  aluResult = aFwd - aluB;
            aluAnd:  aluResult = aFwd & aluB;
            aluOr:   aluResult = aFwd | aluB;
            aluSll:  aluResult = aFwd << shamt;
            aluSra:  aluResult = $signed(aFwd) >>> shamt;
            default: aluResult = '0;  // unsupported op, treated as no-op
        endcase
    end

    // rd sits on B, rs on A
    assign branchTaken = ((op == opBne) && (aluResult != '0)) ||
                         ((op == opBlt) && ($signed(bFwd) < $signed(aFwd)));

    assign redirect = branchTaken || (op == opJ);

    // Falls back to the fetch PC+1 when nothing is taken
    always_comb begin
        if (op == opJ) begin
            redirectPc = target;
        end else if (branchTaken) begin
            redirectPc = dx.pcPlus1 + imm;
        end else begin
            redirectPc = pcPlus1;
        end
    end

    // XM register, B operand carries the sw data
    always_ff @(posedge clock) begin
        if (rst) begin
            xm <= '0;
        end else begin
            xm.instr     <= dx.instr;
            xm.result    <= aluResult;
            xm.storeData <= bFwd;
        end
    end

    // Only control transfers redirect, and the flush keeps the next slot quiet
    redirectOnlyControl: assert property (@(posedge clock) disable iff (rst)
        redirect |-> (op inside {opBne, opBlt, opJ}) ##1 !redirect);

endmodule

`default_nettype wire

/* fetchStage.sv */
/*
  Program counter and FD register.
  The PC is a word index; only the low MEM_ADDR_BITS go to instruction memory.
  A redirect wins over a load stall and flushes FD to a bubble.
*/
`default_nettype none

module fetchStage (
    input  logic             clock,
    input  logic             rst,
    input  logic             loadStall,
    input  logic             redirect,
    input  cpuPkg::wordT     redirectPc,
    output cpuPkg::memAddrT  imemAddr,
    input  cpuPkg::wordT     imemData,
    output cpuPkg::wordT     pcPlus1,
    output cpuPkg::fdPayloadT fd
);
    import cpuPkg::*;

    wordT pc;

    // Sequential next address, also the not-taken value for execute
    assign pcPlus1  = pc + 1'b1;
    assign imemAddr = pc[$bits(memAddrT)-1:0];

    // PC holds under a load stall unless a redirect arrives
    always_ff @(posedge clock) begin
        if (rst) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= redirectPc;
        end else if (!loadStall) begin
            pc <= pcPlus1;
        end
    end

    // FD register, bubble on redirect
    always_ff @(posedge clock) begin
        if (rst || redirect) begin
            fd <= '0;
        end else if (!loadStall) begin
            fd.instr   <= imemData;
            fd.pcPlus1 <= pcPlus1;
        end
    end

    // Stall freezes the fetch address for that cycle
    pcHoldOnStall: assert property (@(posedge clock) disable iff (rst)
        (loadStall && !redirect) |=> (pc == $past(pc)));

endmodule

`default_nettype wire

/* forwardIf.sv */
/*
  Bypass sources from the memory stage toward execute.
  The writes flags are already false for register 0.
*/
`default_nettype none

interface forwardIf;
    import cpuPkg::*;

    // Instruction sitting in XM
    regIdxT xmRd;
    wordT   xmValue;
    logic   xmWrites;

    // Instruction sitting in MW, value is the final writeback data
    regIdxT mwRd;
    wordT   mwValue;
    logic   mwWrites;

    modport source (output xmRd, xmValue, xmWrites, mwRd, mwValue, mwWrites);
    modport sink   (input  xmRd, xmValue, xmWrites, mwRd, mwValue, mwWrites);

endinterface

`default_nettype wire

/* memoryStage.sv */
/*
  Data memory access, MW register and writeback select.
  Memory answers in the same cycle; writes land on the rising edge.
  Store data is refreshed from MW when MW writes the store's rd.
*/
`default_nettype none
`include "cpu_defines.svh"

module memoryStage (
    input  logic              clock,
    input  logic              rst,
    input  cpuPkg::xmPayloadT xm,
    forwardIf.source          fwd,
    output cpuPkg::memAddrT   dmemAddr,
    output cpuPkg::wordT      dmemWriteData,
    output logic              dmemWrite,
    input  cpuPkg::wordT      dmemReadData,
    output logic              regWrite,
    output cpuPkg::regIdxT    regWriteIdx,
    output cpuPkg::wordT      regWriteData
);
    import cpuPkg::*;

    opcodeT xmOp;
    regIdxT xmRd;
    wordT   mwInstr;
    wordT   mwResult;
    wordT   mwReadData;
    opcodeT mwOp;
    regIdxT mwRd;

    assign xmOp = opcodeT'(xm.instr[31:27]);
    assign xmRd = xm.instr[26:22];

    ////////////////////////////////////////
    // Data memory side
    ////////////////////////////////////////
    assign dmemAddr  = xm.result[`MEM_ADDR_BITS-1:0];
    assign dmemWrite = (xmOp == opSw);

    // Store data bypass from writeback
    assign dmemWriteData = (fwd.mwWrites && (fwd.mwRd == xmRd)) ? fwd.mwValue
                                                                : xm.storeData;

    // MW instruction word, bubble after reset
    always_ff @(posedge clock) begin
        if (rst) begin
            mwInstr <= '0;
        end else begin
            mwInstr <= xm.instr;
        end
    end

    // MW data words
    always_ff @(posedge clock) begin
        mwResult   <= xm.result;
        mwReadData <= dmemReadData;
    end

    ////////////////////////////////////////
    // Writeback
    ////////////////////////////////////////
    assign mwOp = opcodeT'(mwInstr[31:27]);
    assign mwRd = mwInstr[26:22];

    assign regWriteIdx  = mwRd;
    assign regWriteData = (mwOp == opLw) ? mwReadData : mwResult;
    assign regWrite     = writesRd(mwOp) && (mwRd != `ZERO_REG);

    // Bypass sources for execute
    assign fwd.xmRd     = xmRd;
    assign fwd.xmValue  = xm.result;
    assign fwd.xmWrites = writesRd(xmOp) && (xmRd != `ZERO_REG);
    assign fwd.mwRd     = mwRd;
    assign fwd.mwValue  = regWriteData;
    assign fwd.mwWrites = regWrite;

    // r0 stays zero in the external register file
    noZeroWrite: assert property (@(posedge clock) disable iff (rst)
        regWrite |-> (regWriteIdx != `ZERO_REG));

endmodule

`default_nettype wire

/* sim.f */
+incdir+.
cpuPkg.sv
forwardIf.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
memoryStage.sv
cpuTop.sv
tbCpu.sv

/* tbCpu.sv */
/*
  Testbench for the five-stage core.
  Models instruction memory, data memory and a write-through register file.
  Program words and expected writes come from cpu_trace.txt in the run directory.
  Expected register writes and stores are matched strictly in program order.
*/
`default_nettype none
`include "cpu_defines.svh"

module tbCpu;
    timeunit 1ns;
    timeprecision 100ps;

    import cpuPkg::*;

    localparam int MEM_WORDS = 1 << `MEM_ADDR_BITS;
    localparam int RUN_LIMIT = 600;
    localparam int DRAIN_CYCLES = 20;

    logic    clock;
    logic    rst;
    memAddrT imemAddr;
    wordT    imemData;
    memAddrT dmemAddr;
    wordT    dmemWriteData;
    logic    dmemWrite;
    wordT    dmemReadData;
    regIdxT  regReadIdxA;
    regIdxT  regReadIdxB;
    wordT    regReadDataA;
    wordT    regReadDataB;
    logic    regWrite;
    regIdxT  regWriteIdx;
    wordT    regWriteData;

    // Memory and register models
    wordT imem [MEM_WORDS];
    wordT dmem [MEM_WORDS];
    wordT regs [`REG_COUNT];

    // Expected results, in order, each tagged with its behavior number
    regIdxT  expRegIdx[$];
    wordT    expRegVal[$];
    int      expRegTest[$];
    memAddrT expStAddr[$];
    wordT    expStData[$];
    int      expStTest[$];

    int remaining [1:6];
    int testErrors [1:6];
    int errorCount;
    int checkCount;
    logic seenFirstWrite;

    cpuTop UUT (
        .clock         (clock),
        .rst           (rst),
        .imemAddr      (imemAddr),
        .imemData      (imemData),
        .dmemAddr      (dmemAddr),
        .dmemWriteData (dmemWriteData),
        .dmemWrite     (dmemWrite),
        .dmemReadData  (dmemReadData),
        .regReadIdxA   (regReadIdxA),
        .regReadIdxB   (regReadIdxB),
        .regReadDataA  (regReadDataA),
        .regReadDataB  (regReadDataB),
        .regWrite      (regWrite),
        .regWriteIdx   (regWriteIdx),
        .regWriteData  (regWriteData)
    );

    always #5 clock = ~clock;

    ////////////////////////////////////////
    // Combinational memory and register reads
    ////////////////////////////////////////
    assign imemData     = imem[imemAddr];
    assign dmemReadData = dmem[dmemAddr];

    // Write-through, r0 always zero
    assign regReadDataA = (regReadIdxA == '0) ? '0 :
                          (regWrite && (regWriteIdx == regReadIdxA)) ? regWriteData :
                          regs[regReadIdxA];
    assign regReadDataB = (regReadIdxB == '0) ? '0 :
                          (regWrite && (regWriteIdx == regReadIdxB)) ? regWriteData :
                          regs[regReadIdxB];

    always @(posedge clock) begin
        if (regWrite && (regWriteIdx != '0)) begin
            regs[regWriteIdx] <= regWriteData;
        end
        if (dmemWrite) begin
            dmem[dmemAddr] <= dmemWriteData;
        end
    end

    function automatic string testName(int t);
        case (t)
            1:       return "dependent ALU chain with bypass";
            2:       return "addi negative, sll and sra";
            3:       return "store, load and load-use stall";
            4:       return "bne and blt taken and not taken";
            5:       return "jump skips its shadow";
            default: return "quiet reset and r0 writes";
        endcase
    endfunction

    task automatic finishItem(int t);
        remaining[t]--;
        if ((remaining[t] == 0) && (t != 6)) begin
            if (testErrors[t] == 0) begin
                $display("Test %0d (%s) passed", t, testName(t));
            end else begin
                $display("Test %0d (%s) failed with %0d errors", t, testName(t),
                         testErrors[t]);
            end
        end
    endtask

    ////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////
    task automatic checkRegWrite(regIdxT idx, wordT val);
        int t;
        checkCount++;
        if (expRegIdx.size() == 0) begin
            $display("Unexpected register write to r%0d at %0t ns", idx, $time);
            errorCount++;
            return;
        end
        t = expRegTest.pop_front();
        if ((idx !== expRegIdx[0]) || (val !== expRegVal[0])) begin
            $display("FAIL %0t ns: register write r%0d=%h, expected r%0d=%h", $time,
                     idx, val, expRegIdx[0], expRegVal[0]);
            errorCount++;
            testErrors[t]++;
        end
        void'(expRegIdx.pop_front());
        void'(expRegVal.pop_front());
        finishItem(t);
    endtask

    task automatic checkStore(memAddrT addr, wordT data);
        int t;
        checkCount++;
        if (expStAddr.size() == 0) begin
            $display("Unexpected store to address %h at %0t ns", addr, $time);
            errorCount++;
            return;
        end
        t = expStTest.pop_front();
        if ((addr !== expStAddr[0]) || (data !== expStData[0])) begin
            $display("FAIL %0t ns: store [%h]=%h, expected [%h]=%h", $time,
                     addr, data, expStAddr[0], expStData[0]);
            errorCount++;
            testErrors[t]++;
        end
        void'(expStAddr.pop_front());
        void'(expStData.pop_front());
        finishItem(t);
    endtask

    // Outputs sampled at the rising edge, before the flops update
    always @(posedge clock) begin
        if (rst || !seenFirstWrite) begin
            if (dmemWrite || (rst && regWrite)) begin
                $display("FAIL %0t ns: write strobe active before first write", $time);
                errorCount++;
                testErrors[6]++;
            end
        end
        if (!rst && regWrite) begin
            seenFirstWrite = 1'b1;
            if (regWriteIdx == '0) begin
                $display("FAIL %0t ns: register write to r0", $time);
                errorCount++;
                testErrors[6]++;
            end
            checkRegWrite(regWriteIdx, regWriteData);
        end
        if (!rst && dmemWrite) begin
            checkStore(dmemAddr, dmemWriteData);
        end
    end

    ////////////////////////////////////////
    // Trace reader
    ////////////////////////////////////////
    task automatic readTrace(output int progWords);
        int    fd;
        int    t;
        int    a;
        int    b;
        string line;
        progWords = 0;
        fd = $fopen("cpu_trace.txt", "r");
        if (fd == 0) begin
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() == 0) begin
                continue;
            end
            case (line.getc(0))
                "I": begin
                    if ($sscanf(line, "I %h", a) == 1) begin
                        imem[progWords] = wordT'(a);
                        progWords++;
                    end
                end
                "R": begin
                    if ($sscanf(line, "R %d %d %h", t, a, b) == 3) begin
                        expRegTest.push_back(t);
                        expRegIdx.push_back(regIdxT'(a));
                        expRegVal.push_back(wordT'(b));
                        remaining[t]++;
                    end
                end
                "S": begin
                    if ($sscanf(line, "S %d %h %h", t, a, b) == 3) begin
                        expStTest.push_back(t);
                        expStAddr.push_back(memAddrT'(a));
                        expStData.push_back(wordT'(b));
                        remaining[t]++;
                    end
                end
                default: ;  // comment or blank
            endcase
        end
        $fclose(fd);
    endtask

    initial begin
        int progWords;
        int cycles;
        $timeformat(-9, 0, "", 0);
        clock = 1'b0;
        rst = 1'b1;
        errorCount = 0;
        checkCount = 0;
        seenFirstWrite = 1'b0;
        for (int i = 1; i <= 6; i++) begin
            remaining[i] = 0;
            testErrors[i] = 0;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = '0;
            dmem[i] = '0;
        end
        for (int i = 0; i < `REG_COUNT; i++) begin
            regs[i] = '0;
        end

        readTrace(progWords);
        if (progWords == 0) begin
            $display("The trace file could not be read or holds no program");
            errorCount++;
        end

        repeat (16) @(posedge clock);
        #1 rst = 1'b0;

        // Run until every expected write has been seen
        cycles = 0;
        while (((expRegIdx.size() + expStAddr.size()) != 0) && (cycles < RUN_LIMIT)) begin
            @(posedge clock);
            cycles++;
        end
        if ((expRegIdx.size() + expStAddr.size()) != 0) begin
            $display("Timed out with %0d register writes and %0d stores still missing",
                     expRegIdx.size(), expStAddr.size());
            errorCount++;
        end

        // Extra cycles catch stray writes after the program halts
        cycles = 0;
        while (cycles < DRAIN_CYCLES) begin
            @(posedge clock);
            cycles++;
        end

        if (testErrors[6] == 0) begin
            $display("Test 6 (%s) passed", testName(6));
        end else begin
            $display("Test 6 (%s) failed with %0d errors", testName(6), testErrors[6]);
        end
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
